//--- build.f
cnn_num_pkg.sv
cnn_reg_pkg.sv
mac_accum.sv
rescale.sv
cnn_cfg_regs.sv
cnn_dot_top.sv
tb_clk_gen.sv
tb_cnn_dot.sv

//--- Bender.yml
package:
  name: cnn_dot

sources:
  - cnn_num_pkg.sv
  - cnn_reg_pkg.sv
  - mac_accum.sv
  - rescale.sv
  - cnn_cfg_regs.sv
  - cnn_dot_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_cnn_dot.sv

//--- tb_cnn_dot.sv
`timescale 1ns/1ps

module tb_cnn_dot import cnn_num_pkg::*, cnn_reg_pkg::*; ();

    localparam int     WAIT_MAX = 50;
    localparam longint NUM_MOD  = longint'(1) << NUM_WIDTH;

    typedef struct {
        string name;
        int    shift;
        int    bias;
        int    taps;
        bit    rnd;
        img_t  pix;
        img_t  wgt;
    } frame_t;

    // rnd picks small random pairs, otherwise every tap uses pix and wgt
    frame_t frames [15] = '{
        '{"rand_s0",     0,      0, 4, 1'b1,      0,      0},
        '{"rand_s5",     5,     -3, 8, 1'b1,      0,      0},
        '{"rand_s11",   11,    100, 6, 1'b1,      0,      0},
        '{"rand_s17",   17,      0, 3, 1'b1,      0,      0},
        '{"max_edge",    0,      0, 1, 1'b0,      1,  32767},
        '{"max_over",    0,      1, 1, 1'b0,      1,  32767},
        '{"min_edge",    0,      0, 1, 1'b0, -32768,      1},
        '{"min_over",    0,     -1, 1, 1'b0, -32768,      1},
        '{"big_pos",     4,      0, 2, 1'b0,  32767,  32767},
        '{"big_neg",     4,      0, 2, 1'b0, -32768,  32767},
        '{"shift_edge", 17,      0, 4, 1'b0,  32767,  32767},
        '{"neg_bias",    2, -30000, 4, 1'b0,    100,     50},
        '{"wrap_neg",   17,      0, 5, 1'b0, -32768, -32768},
        '{"wrap_pos",   17,      0, 9, 1'b0, -32768, -32768},
        '{"bias_only",   3,  -4000, 1, 1'b0,      0,      0}
    };

    logic      clk;
    logic      rst_n;
    pix_beat_t pix_in;
    img_beat_t img_out;
    wb_req_t   wb_req;
    wb_rsp_t   wb_rsp;

    int err_value;
    int err_other;
    int res_seen;
    int sat_seen;

    tb_clk_gen i_clk (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cnn_dot_top i_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .pix_in  (pix_in),
        .img_out (img_out),
        .wb_req  (wb_req),
        .wb_rsp  (wb_rsp)
    );

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Done: errors found");
        $finish;
    endtask

    // biased sum wraps at the accumulator width, then shift and clip
    function automatic void ref_model(input longint acc, input int bias, input int shift,
                                      output img_t data, output logic sat);
        longint v;
        int     s;
        s = (shift > SHIFT_MAX) ? SHIFT_MAX : shift;
        v = (acc + longint'(bias)) & (NUM_MOD - 1);
        if (v >= NUM_MOD / 2) begin
            v = v - NUM_MOD;
        end
        v = v >>> s;
        sat = 1'b1;
        if (v > longint'(IMG_MAX)) begin
            data = IMG_MAX;
        end else if (v < longint'(IMG_MIN)) begin
            data = IMG_MIN;
        end else begin
            data = img_t'(v);
            sat  = 1'b0;
        end
    endfunction

    task automatic check_img(input string name, input img_t exp_data, input logic exp_sat,
                             input img_beat_t got);
        res_seen++;
        sat_seen += exp_sat;
        if (got.data !== exp_data || got.sat !== exp_sat) begin
            err_value++;
            $display("Fail %s: expected %0d (sat %0b), actual %0d (sat %0b)",
                     name, exp_data, exp_sat, got.data, got.sat);
        end
    endtask

    task automatic check_word(input string name, input wb_data_t exp_dat, input wb_data_t got);
        if (got !== exp_dat) begin
            err_value++;
            $display("Fail %s: expected 0x%08h, actual 0x%08h", name, exp_dat, got);
        end
    endtask

    task automatic bus_access(input logic we, input wb_adr_t adr, input wb_data_t dat,
                              output wb_data_t rdat);
        int n;
        @(negedge clk);
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        for (n = 0; n < WAIT_MAX; n++) begin
            @(negedge clk);
            if (wb_rsp.ack) break;
        end
        if (!wb_rsp.ack) report_timeout("wishbone ack");
        rdat   = wb_rsp.dat;
        wb_req = '0;
    endtask

    // idles the input and counts cycles until an output is valid
    task automatic wait_img(output int cycles);
        for (cycles = 1; cycles <= WAIT_MAX; cycles++) begin
            @(negedge clk);
            pix_in = '0;
            if (img_out.valid) break;
        end
        if (!img_out.valid) report_timeout("output valid");
    endtask

    task automatic run_frame(input frame_t f);
        longint   acc;
        img_t     p;
        img_t     w;
        img_t     exp_data;
        logic     exp_sat;
        int       lat;
        wb_data_t rd;
        bus_access(1'b1, REG_SHIFT, wb_data_t'(f.shift), rd);
        bus_access(1'b1, REG_BIAS, wb_data_t'(f.bias), rd);
        acc = 0;
        for (int i = 0; i < f.taps; i++) begin
            p = f.pix;
            w = f.wgt;
            if (f.rnd) begin
                p = img_t'(int'($urandom_range(127, 0)) - 64);
                w = img_t'(int'($urandom_range(127, 0)) - 64);
            end
            acc += longint'(p) * longint'(w);
            @(negedge clk);
            pix_in = '{valid: 1'b1, last: (i == f.taps - 1), pixel: p, weight: w};
        end
        wait_img(lat);
        if (lat != 6) begin
            err_other++;
            $display("%s: output came %0d cycles after last, not 6", f.name, lat);
        end
        ref_model(acc, f.bias, f.shift, exp_data, exp_sat);
        check_img(f.name, exp_data, exp_sat, img_out);
    endtask

    // single-tap frames every cycle, shift written while they are in flight
    task automatic run_back_to_back();
        img_t     pv [6];
        img_t     exp_data;
        logic     exp_sat;
        int       lat;
        wb_data_t rd;
        bus_access(1'b1, REG_SHIFT, 32'd2, rd);
        bus_access(1'b1, REG_BIAS, 32'd0, rd);
        for (int k = 0; k < 6; k++) begin
            pv[k] = img_t'(1000 * (k + 1));
            @(negedge clk);
            pix_in = '{valid: 1'b1, last: 1'b1, pixel: pv[k], weight: 16'sd7};
            if (k == 3) wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: REG_SHIFT, dat: 32'd6};
            if (k == 4) wb_req = '0;
        end
        wait_img(lat);
        // frame 0 closed five beats before the burst ended
        if (lat != 1) begin
            err_other++;
            $display("b2b frame 0: output came %0d cycles after last, not 6", lat + 5);
        end
        for (int k = 0; k < 6; k++) begin
            if (k > 0) @(negedge clk);
            if (!img_out.valid) begin
                err_other++;
                $display("b2b frame %0d: no output in its cycle", k);
            end
            // the first two frames reach rescale before the new shift
            ref_model(longint'(pv[k]) * 7, 0, (k < 2) ? 2 : 6, exp_data, exp_sat);
            check_img($sformatf("b2b_%0d", k), exp_data, exp_sat, img_out);
        end
    endtask

    initial begin
        wb_data_t rd;
        int       n;
        pix_in    = '0;
        wb_req    = '0;
        err_value = 0;
        err_other = 0;
        res_seen  = 0;
        sat_seen  = 0;
        void'($urandom(82829));
        for (n = 0; n < WAIT_MAX && !rst_n; n++) @(negedge clk);
        if (!rst_n) report_timeout("reset release");

        foreach (frames[i]) run_frame(frames[i]);
        run_back_to_back();

        bus_access(1'b1, REG_SHIFT, 32'd25, rd);
        bus_access(1'b0, REG_SHIFT, 32'd0, rd);
        check_word("shift_clamp", 32'd17, rd);
        bus_access(1'b1, REG_BIAS, 32'hffff_8001, rd);
        bus_access(1'b0, REG_BIAS, 32'd0, rd);
        check_word("bias_read", 32'hffff_8001, rd);

        bus_access(1'b0, REG_RES_CNT, 32'd0, rd);
        check_word("res_cnt", wb_data_t'(res_seen), rd);
        bus_access(1'b0, REG_SAT_CNT, 32'd0, rd);
        check_word("sat_cnt", wb_data_t'(sat_seen), rd);
        bus_access(1'b1, REG_RES_CNT, 32'd5, rd);
        bus_access(1'b1, REG_SAT_CNT, 32'd5, rd);
        bus_access(1'b0, REG_RES_CNT, 32'd0, rd);
        check_word("res_cnt_clear", 32'd0, rd);
        bus_access(1'b0, REG_SAT_CNT, 32'd0, rd);
        check_word("sat_cnt_clear", 32'd0, rd);

        $display("%0d value errors, %0d other errors", err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // reset held for 8 cycles, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

//--- cnn_dot_top.sv
`timescale 1ns/1ps

module cnn_dot_top import cnn_num_pkg::*, cnn_reg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pix_beat_t pix_in,
    output img_beat_t img_out,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp
);

    num_beat_t sums;
    cnn_cfg_t  cfg;

    // configuration, and counting of the outputs
    cnn_cfg_regs i_regs (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .img    (img_out),
        .cfg    (cfg)
    );

    mac_accum i_mac (
        .clk   (clk),
        .rst_n (rst_n),
        .pix   (pix_in),
        .bias  (cfg.bias),
        .sums  (sums)
    );

    rescale i_rescale (
        .clk   (clk),
        .rst_n (rst_n),
        .shift (cfg.shift),
        .sums  (sums),
        .img   (img_out)
    );

endmodule

//--- cnn_cfg_regs.sv
`timescale 1ns/1ps

module cnn_cfg_regs import cnn_num_pkg::*, cnn_reg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  wb_req_t   wb_req,
    output wb_rsp_t   wb_rsp,
    input  img_beat_t img,
    output cnn_cfg_t  cfg
);

    logic     access;
    logic     wr_en;
    logic     ack_q;
    wb_data_t rd_dat;
    shift_t   shift_q;
    num_t     bias_q;
    wb_data_t res_cnt;
    wb_data_t sat_cnt;

    // new access only while no ack is out, the master drops stb on ack
    assign access = wb_req.cyc & wb_req.stb & ~ack_q;
    assign wr_en  = access & wb_req.we;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            shift_q <= '0;
            bias_q  <= '0;
            res_cnt <= '0;
            sat_cnt <= '0;
        end else begin
            ack_q <= access;
            if (wr_en && wb_req.adr == REG_SHIFT) begin
                if (wb_req.dat > wb_data_t'(SHIFT_MAX)) begin
                    shift_q <= shift_t'(SHIFT_MAX);
                end else begin
                    shift_q <= wb_req.dat[$bits(shift_t)-1:0];
                end
            end
            if (wr_en && wb_req.adr == REG_BIAS) begin
                bias_q <= num_t'($signed(wb_req.dat));
            end
            // any write clears a counter, and wins over a count
            if (wr_en && wb_req.adr == REG_RES_CNT) begin
                res_cnt <= '0;
            end else if (img.valid) begin
                res_cnt <= res_cnt + 1'b1;
            end
            if (wr_en && wb_req.adr == REG_SAT_CNT) begin
                sat_cnt <= '0;
            end else if (img.valid && img.sat) begin
                sat_cnt <= sat_cnt + 1'b1;
            end
        end
    end

    // read data is presented with ack
    always_ff @(posedge clk) begin
        case (wb_req.adr)
            REG_SHIFT:   rd_dat <= wb_data_t'(shift_q);
            REG_BIAS:    rd_dat <= bias_q[WB_DW-1:0];
            REG_RES_CNT: rd_dat <= res_cnt;
            default:     rd_dat <= sat_cnt;
        endcase
    end

    assign wb_rsp = '{ack: ack_q, dat: rd_dat};
    assign cfg    = '{shift: shift_q, bias: bias_q};

    // single cycle ack per access
    a_ack_single: assert property (
        @(posedge clk) disable iff (!rst_n) ack_q |=> !ack_q
    );

endmodule

//--- rescale.sv
`timescale 1ns/1ps

module rescale import cnn_num_pkg::*, cnn_reg_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  shift_t    shift,
    input  num_beat_t sums,
    output img_beat_t img
);

    logic [3:0] valid_q;

    // stage 1
    num_t                  num_1p;
    num_t                  shifted_1p;
    logic [NUM_AWIDTH-1:0] top_1p;

    // stage 2
    logic [NUM_WIDTH-1:0]  high_mask;
    logic                  bound_max_2p;
    logic                  bound_min_2p;
    img_t                  data_2p;

    // stage 3 and 4
    img_t                  data_3p;
    logic                  sat_3p;
    img_t                  data_4p;
    logic                  sat_4p;

    // valid walks alongside the four data stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[2:0], sums.valid};
        end
    end

    // shift is taken with the number, so later changes do not disturb it
    always_ff @(posedge clk) begin
        num_1p     <= sums.num;
        shifted_1p <= sums.num >>> shift;
        // bit of the number that lands on the image sign bit
        top_1p     <= NUM_AWIDTH'(IMG_WIDTH - 1) + NUM_AWIDTH'(shift);
    end

    // every bit from the top position upward must match the sign
    assign high_mask = {NUM_WIDTH{1'b1}} << top_1p;

    always_ff @(posedge clk) begin
        bound_max_2p <= ~num_1p[NUM_WIDTH-1] & (|(num_1p & high_mask));
        bound_min_2p <= num_1p[NUM_WIDTH-1] & (|(~num_1p & high_mask));
        data_2p      <= shifted_1p[IMG_WIDTH-1:0];
    end

    always_ff @(posedge clk) begin
        if (bound_min_2p) begin
            data_3p <= IMG_MIN;
        end else if (bound_max_2p) begin
            data_3p <= IMG_MAX;
        end else begin
            data_3p <= data_2p;
        end
        sat_3p <= bound_min_2p | bound_max_2p;
    end

    always_ff @(posedge clk) begin
        data_4p <= data_3p;
        sat_4p  <= sat_3p;
    end

    assign img = '{valid: valid_q[3], sat: sat_4p, data: data_4p};

    // the register block clamps shift on write
    a_shift_in_range: assert property (
        @(posedge clk) disable iff (!rst_n) shift <= SHIFT_MAX
    );

    // clipping and shifting never flip the sign
    a_sign_kept: assert property (
        @(posedge clk) disable iff (!rst_n)
        img.valid |-> img.data[IMG_WIDTH-1] == $past(sums.num[NUM_WIDTH-1], 4)
    );

endmodule

//--- mac_accum.sv
`timescale 1ns/1ps

module mac_accum import cnn_num_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  pix_beat_t pix,
    input  num_t      bias,
    output num_beat_t sums
);

    // full precision product of two image samples
    logic signed [2*IMG_WIDTH-1:0] prod_q;
    logic                          prod_valid;
    logic                          prod_last;

    num_t acc_q;
    num_t sum_num;
    logic sum_valid;

    // stage 1: product
    always_ff @(posedge clk) begin
        prod_q <= pix.pixel * pix.weight;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prod_valid <= 1'b0;
            prod_last  <= 1'b0;
        end else begin
            prod_valid <= pix.valid;
            prod_last  <= pix.valid & pix.last;
        end
    end

    // stage 2: running sum, cleared as the frame closes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_q     <= '0;
            sum_valid <= 1'b0;
        end else begin
            sum_valid <= prod_valid & prod_last;
            if (prod_valid) begin
                if (prod_last) begin
                    acc_q <= '0;
                end else begin
                    acc_q <= acc_q + num_t'(prod_q);
                end
            end
        end
    end

    // bias is added only to the closing sum, wraps at NUM_WIDTH
    always_ff @(posedge clk) begin
        sum_num <= acc_q + num_t'(prod_q) + bias;
    end

    assign sums = '{valid: sum_valid, num: sum_num};

    // frame marker only means something on a valid beat
    a_last_needs_valid: assert property (
        @(posedge clk) disable iff (!rst_n) pix.last |-> pix.valid
    );

endmodule

//--- cnn_reg_pkg.sv
package cnn_reg_pkg;

    import cnn_num_pkg::*;

    // wishbone data and word address widths
    localparam int WB_DW = 32;
    localparam int WB_AW = 2;

    typedef logic [WB_DW-1:0] wb_data_t;
    typedef logic [WB_AW-1:0] wb_adr_t;

    // register word addresses
    localparam wb_adr_t REG_SHIFT   = 2'd0;
    localparam wb_adr_t REG_BIAS    = 2'd1;
    localparam wb_adr_t REG_RES_CNT = 2'd2;
    localparam wb_adr_t REG_SAT_CNT = 2'd3;

    // beyond this the image window would leave the accumulator word
    localparam int SHIFT_MAX = NUM_WIDTH - IMG_WIDTH;

    typedef logic [4:0] shift_t;

    typedef struct packed {
        logic     cyc;
        logic     stb;
        logic     we;
        wb_adr_t  adr;
        wb_data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic     ack;
        wb_data_t dat;
    } wb_rsp_t;

    // datapath configuration
    typedef struct packed {
        shift_t shift;
        num_t   bias;
    } cnn_cfg_t;

endpackage

//--- cnn_num_pkg.sv
package cnn_num_pkg;

    // image sample and accumulator widths
    localparam int IMG_WIDTH  = 16;
    localparam int NUM_WIDTH  = 33;

    // width of a bit index into an accumulator number
    localparam int NUM_AWIDTH = $clog2(NUM_WIDTH);

    typedef logic signed [IMG_WIDTH-1:0] img_t;
    typedef logic signed [NUM_WIDTH-1:0] num_t;

    // saturation limits of the image range
    localparam img_t IMG_MAX = {1'b0, {(IMG_WIDTH-1){1'b1}}};
    localparam img_t IMG_MIN = {1'b1, {(IMG_WIDTH-1){1'b0}}};

    // pixel and weight pair, last marks the end of a frame
    typedef struct packed {
        logic valid;
        logic last;
        img_t pixel;
        img_t weight;
    } pix_beat_t;

    // biased dot product leaving the accumulator
    typedef struct packed {
        logic valid;
        num_t num;
    } num_beat_t;

    // rescaled sample, sat set when clipped to a limit
    typedef struct packed {
        logic valid;
        logic sat;
        img_t data;
    } img_beat_t;

endpackage
